// File: design/gf_pkg.sv
package gf_pkg;

	// Field degree, GF(2^4)
	localparam int gf_m = 4;

	// Multiplicative group order
	localparam int gf_order = (1 << gf_m) - 1;

	typedef logic [gf_m-1:0] gf_elem_t;

	// x^4 + x + 1 with the x^4 term implied
	localparam gf_elem_t gf_poly = 4'b0011;

	localparam gf_elem_t gf_zero = '0;
	localparam gf_elem_t gf_one = gf_elem_t'(1);

	// Multiply by alpha, one shift plus reduction
	function automatic gf_elem_t gf_xtime(gf_elem_t a);
		gf_elem_t r;
		r = {a[gf_m-2:0], 1'b0};
		if (a[gf_m-1])
			r = r ^ gf_poly;
		return r;
	endfunction

	// Shift-and-add product, reduced after every shift
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = gf_zero;
		sh = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				acc = acc ^ sh;
			sh = gf_xtime(sh);
		end
		return acc;
	endfunction

	function automatic gf_elem_t gf_sq(gf_elem_t a);
		return gf_mul(a, a);
	endfunction

	// alpha^p for a constant p, exponent taken modulo the group order
	function automatic gf_elem_t gf_alpha_pow(int p);
		gf_elem_t r;
		r = gf_one;
		for (int i = 0; i < p % gf_order; i++)
			r = gf_xtime(r);
		return r;
	endfunction

endpackage

// File: design/bch_pkg.sv
package bch_pkg;

	import gf_pkg::*;

	// Codeword length and correction capability
	localparam int bch_n = (1 << gf_m) - 1;
	localparam int bch_t = 3;

	// S_1 .. S_2T
	localparam int bch_syn_count = 2 * bch_t;

	// Slots presented to the key-equation solver
	localparam int bch_slot_count = 2 * bch_t - 1;

	typedef struct packed {
		gf_elem_t [bch_syn_count:1] s;
	} syndrome_set_t;

	typedef struct packed {
		gf_elem_t [bch_slot_count-1:0] slot;
	} shuffled_set_t;

	// Bit counter state, same width as a field element
	typedef logic [gf_m-1:0] lfsr_state_t;

	localparam lfsr_state_t lfsr_seed = '1;

	// Fibonacci step, shift left with the feedback entering at bit 0.
	// Tap positions follow the primitive polynomial in reversed order.
	function automatic lfsr_state_t lfsr_step(lfsr_state_t s);
		logic fb;
		fb = s[gf_m-1];
		for (int k = 1; k < gf_m; k++)
			fb = fb ^ (gf_poly[k] & s[gf_m-1-k]);
		return {s[gf_m-2:0], fb};
	endfunction

	function automatic lfsr_state_t lfsr_after(int steps);
		lfsr_state_t s;
		s = lfsr_seed;
		for (int i = 0; i < steps; i++)
			s = lfsr_step(s);
		return s;
	endfunction

	// State seen while the final codeword bit is on data_in
	localparam lfsr_state_t lfsr_last = lfsr_after(bch_n - 2);

endpackage

// File: design/lfsr_counter.sv
`timescale 1ns/1ns

module lfsr_counter (
	input logic clk,
	input logic reset,
	input logic load,
	input logic enable,
	output logic last
);

	import bch_pkg::*;

	lfsr_state_t state;

	// Maximal-length sequence stands in for a binary counter.
	// The seed is loaded with the first bit, so the count trails the
	// bit position by one.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= lfsr_seed;
		end else if (load) begin
			state <= lfsr_seed;
		end else if (enable) begin
			state <= lfsr_step(state);
		end
	end

	// High during the cycle that carries r_0
	assign last = (state == lfsr_last);

endmodule

// File: design/syndrome_accum.sv
`timescale 1ns/1ns

module syndrome_accum #(
	parameter int J = 1
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic enable,
	input logic data_in,
	output gf_pkg::gf_elem_t syn
);

	import gf_pkg::*;

	// Constant multiplier alpha^J
	localparam gf_elem_t alpha_j = gf_alpha_pow(J);

	gf_elem_t bit_in;
	gf_elem_t horner_next;

	// Received bit lands in the constant term
	assign bit_in = {{(gf_m-1){1'b0}}, data_in};

	// Horner step, syn * alpha^J + r_i
	assign horner_next = gf_mul(syn, alpha_j) ^ bit_in;

	always_ff @(posedge clk) begin
		if (reset) begin
			syn <= gf_zero;
		end else if (start) begin
			// First bit starts a fresh sum, any old word is dropped
			syn <= bit_in;
		end else if (enable) begin
			syn <= horner_next;
		end
	end

endmodule

// File: design/bch_syndrome.sv
`timescale 1ns/1ns

module bch_syndrome (
	input logic clk,
	input logic reset,
	input logic start,
	input logic data_in,
	output logic done,
	output bch_pkg::syndrome_set_t syndromes,
	output logic has_errors
);

	import gf_pkg::*;
	import bch_pkg::*;

	logic busy;
	logic last;

	// Odd syndromes straight from the accumulators
	gf_elem_t odd_syn [bch_t];

	// Full set, index j holds S_j
	gf_elem_t syn_arr [1:bch_syn_count];

	lfsr_counter counter_i (
		.clk(clk),
		.reset(reset),
		.load(start),
		.enable(busy),
		.last(last)
	);

	// busy covers bits r_(N-2) .. r_0, done follows the last one
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
			end else if (busy && last) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	genvar k;
	generate
		for (k = 0; k < bch_t; k++) begin : accum_gen
			syndrome_accum #(
				.J(2 * k + 1)
			) accum_i (
				.clk(clk),
				.reset(reset),
				.start(start),
				.enable(busy),
				.data_in(data_in),
				.syn(odd_syn[k])
			);
		end
	endgenerate

	// Binary code, so S_2j = S_j^2
	genvar j;
	generate
		for (j = 1; j <= bch_syn_count; j++) begin : expand_gen
			if (j % 2 == 1) begin : odd_g
				assign syn_arr[j] = odd_syn[(j - 1) / 2];
			end else begin : even_g
				assign syn_arr[j] = gf_sq(syn_arr[j / 2]);
			end
		end
	endgenerate

	always_comb begin
		for (int i = 1; i <= bch_syn_count; i++)
			syndromes.s[i] = syn_arr[i];
	end

	// Only meaningful once the word is complete; held until next start
	assign has_errors = !busy && (|syndromes);

endmodule

// File: design/syndrome_shuffle.sv
`timescale 1ns/1ns

module syndrome_shuffle (
	input logic clk,
	input logic reset,
	input logic load,
	input logic rotate,
	input bch_pkg::syndrome_set_t syn_in,
	output bch_pkg::shuffled_set_t syn_shuffled
);

	import bch_pkg::*;

	// For small T one slot keeps its loaded value through all rotations
	function automatic bit is_fixed(int i);
		return (bch_t < 4) && (i == bch_t + 1);
	endfunction

	// Syndrome index copied into slot i on load
	function automatic int load_src(int i);
		if (is_fixed(i))
			return 3 * bch_t - i - 1;
		return ((2 * bch_t + 1 - i) % bch_slot_count) + 1;
	endfunction

	// Slot that feeds slot i on each rotate strobe
	function automatic int rot_src(int i);
		return (i + 2 * bch_t - 3) % bch_slot_count;
	endfunction

	// Load wins over rotate on the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			syn_shuffled <= '0;
		end else if (load) begin
			for (int i = 0; i < bch_slot_count; i++)
				syn_shuffled.slot[i] <= syn_in.s[load_src(i)];
		end else if (rotate) begin
			for (int i = 0; i < bch_slot_count; i++) begin
				if (!is_fixed(i))
					syn_shuffled.slot[i] <= syn_shuffled.slot[rot_src(i)];
			end
		end
	end

endmodule

// File: design/bch_syndrome_unit.sv
`timescale 1ns/1ns

module bch_syndrome_unit (
	input logic clk,
	input logic reset,
	input logic start,
	input logic data_in,
	input logic shuffle_ce,
	output logic done,
	output bch_pkg::syndrome_set_t syndromes,
	output logic has_errors,
	output bch_pkg::shuffled_set_t syn_shuffled
);

	// Serial front end, one bit per clock
	bch_syndrome syndrome_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_in(data_in),
		.done(done),
		.syndromes(syndromes),
		.has_errors(has_errors)
	);

	// Captures the set on done, then rotates on shuffle_ce
	syndrome_shuffle shuffle_i (
		.clk(clk),
		.reset(reset),
		.load(done),
		.rotate(shuffle_ce),
		.syn_in(syndromes),
		.syn_shuffled(syn_shuffled)
	);

endmodule

// File: verification/bch_syndrome_checker.sv
`timescale 1ns/1ns

module bch_syndrome_checker (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done,
	input bch_pkg::syndrome_set_t syndromes,
	input logic has_errors
);

	import bch_pkg::*;

	// done is a single pulse, and the next one needs a whole new word
	done_spacing: assert property (@(posedge clk) disable iff (reset)
		done |=> (!done) [*bch_n-1])
		else $error("done pulses closer than one codeword apart");

	// Uninterrupted word gives done exactly N cycles after start
	done_latency: assert property (@(posedge clk) disable iff (reset)
		start ##1 (!start) [*bch_n-1] |=> done)
		else $error("done missing N cycles after start");

	// Outside a word the results hold until the next start
	result_hold: assert property (@(posedge clk) disable iff (reset)
		(!busy && !start) |=> ($stable(syndromes) && $stable(has_errors)))
		else $error("syndromes or has_errors changed while idle");

endmodule

bind bch_syndrome bch_syndrome_checker checker_i (
	.clk(clk),
	.reset(reset),
	.start(start),
	.busy(busy),
	.done(done),
	.syndromes(syndromes),
	.has_errors(has_errors)
);

// File: verification/bch_syndrome_tb.sv
`timescale 1ns/1ns

module bch_syndrome_tb;

	import gf_pkg::*;
	import bch_pkg::*;

	// Word transfers over all tests, sizes the watchdog
	localparam int word_runs = 31;
	localparam int reset_cycles = 10;
	localparam logic [14:0] gen_word = 15'h0537;

	logic clk;
	logic reset;
	logic start;
	logic data_in;
	logic shuffle_ce;
	logic done;
	logic has_errors;
	syndrome_set_t syndromes;
	shuffled_set_t syn_shuffled;

	int seed = 14489;
	int errors = 0;
	int checks = 0;
	int done_pulses = 0;

	bch_syndrome_unit bch_syndrome_unit_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_in(data_in),
		.shuffle_ce(shuffle_ce),
		.done(done),
		.syndromes(syndromes),
		.has_errors(has_errors),
		.syn_shuffled(syn_shuffled)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (done)
			done_pulses <= done_pulses + 1;
	end

	initial begin
		repeat (word_runs * 40 + reset_cycles) @(posedge clk);
		$display("Timeout: run still going after %0d cycles", word_runs * 40 + reset_cycles);
		$display("Verification failed");
		$finish;
	end

	// Reference GF(16), alpha is a root of x^4 + x + 1
	function automatic gf_elem_t alpha_pow(int e);
		gf_elem_t r;
		r = 4'b0001;
		for (int k = 0; k < e % 15; k++)
			r = {r[2:0], 1'b0} ^ (r[3] ? 4'b0011 : 4'b0000);
		return r;
	endfunction

	function automatic int log_of(gf_elem_t x);
		for (int e = 0; e < 15; e++) begin
			if (alpha_pow(e) == x)
				return e;
		end
		return -1;
	endfunction

	function automatic gf_elem_t square(gf_elem_t x);
		if (x == 4'b0000)
			return 4'b0000;
		return alpha_pow(2 * log_of(x));
	endfunction

	// S_j as the plain sum of r_i * alpha^(ij)
	function automatic gf_elem_t model_syn(logic [14:0] w, int j);
		gf_elem_t s;
		s = 4'b0000;
		for (int i = 0; i < 15; i++) begin
			if (w[i])
				s = s ^ alpha_pow(i * j);
		end
		return s;
	endfunction

	function automatic int load_index(int i);
		if (bch_t < 4 && i == bch_t + 1)
			return 3 * bch_t - i - 1;
		return ((2 * bch_t + 1 - i) % bch_slot_count) + 1;
	endfunction

	// Highest-order bit goes out with start
	task drive_word(input logic [14:0] w, input int nbits);
		@(posedge clk);
		start <= 1'b1;
		data_in <= w[14];
		for (int i = 1; i < nbits; i++) begin
			@(posedge clk);
			start <= 1'b0;
			data_in <= w[14 - i];
		end
	endtask

	task wait_done(output int latency);
		bit seen;
		seen = 0;
		latency = bch_n - 1;
		while (!seen && latency < 40) begin
			@(posedge clk);
			start <= 1'b0;
			data_in <= 1'b0;
			latency++;
			@(negedge clk);
			if (done)
				seen = 1;
		end
		checks++;
		if (!seen) begin
			$display("Error at %0t: done never arrived after the word", $time);
			errors++;
		end else if (latency != bch_n) begin
			$display("Fail at %0t: done %0d cycles after start, expected %0d", $time,
				latency, bch_n);
			errors++;
		end
	endtask

	task check_syndromes(input logic [14:0] w);
		gf_elem_t expected;
		bit any;
		any = 0;
		for (int j = 1; j <= bch_syn_count; j++) begin
			expected = model_syn(w, j);
			any = any | (expected != 4'b0000);
			checks++;
			if (syndromes.s[j] !== expected) begin
				$display("Fail at %0t: S%0d = %h, expected %h", $time, j, syndromes.s[j],
					expected);
				errors++;
			end
		end
		for (int j = 1; j <= bch_t; j++) begin
			checks++;
			if (syndromes.s[2 * j] !== square(syndromes.s[j])) begin
				$display("Fail at %0t: S%0d is not S%0d squared", $time, 2 * j, j);
				errors++;
			end
		end
		checks++;
		if (has_errors !== any) begin
			$display("Fail at %0t: has_errors = %b, expected %b", $time, has_errors, any);
			errors++;
		end
	endtask

	task run_word(input logic [14:0] w);
		int latency;
		drive_word(w, bch_n);
		wait_done(latency);
		check_syndromes(w);
	endtask

	task compare_slots(input gf_elem_t want [bch_slot_count]);
		for (int i = 0; i < bch_slot_count; i++) begin
			checks++;
			if (syn_shuffled.slot[i] !== want[i]) begin
				$display("Fail at %0t: slot %0d = %h, expected %h", $time, i,
					syn_shuffled.slot[i], want[i]);
				errors++;
			end
		end
	endtask

	task report(input string name, input int errors_before);
		$display("%-20s %s", name, (errors == errors_before) ? "ok" : "FAILED");
	endtask

	task zero_word();
		int e0;
		e0 = errors;
		run_word(15'h0000);
		report("zero word", e0);
	endtask

	task single_bits();
		int e0;
		logic [14:0] w;
		e0 = errors;
		for (int i = 0; i < 15; i += 7) begin
			w = '0;
			w[i] = 1'b1;
			run_word(w);
		end
		report("single bits", e0);
	endtask

	// g(x) of the (15,5) code is itself a codeword
	task codeword_flips();
		int e0;
		e0 = errors;
		run_word(gen_word);
		checks++;
		if (syndromes !== '0) begin
			$display("Fail at %0t: codeword gave syndromes %h", $time, syndromes);
			errors++;
		end
		run_word(gen_word ^ 15'h0001);
		run_word(gen_word ^ 15'h0880);
		run_word(gen_word ^ 15'h4210);
		report("codeword flips", e0);
	endtask

	task random_words();
		int e0;
		int r;
		e0 = errors;
		repeat (20) begin
			r = $random(seed);
			run_word(r[14:0]);
		end
		report("random words", e0);
	endtask

	task shuffle_order();
		gf_elem_t want [bch_slot_count];
		gf_elem_t prev [bch_slot_count];
		int e0;
		int r;
		e0 = errors;
		r = $random(seed);
		run_word(r[14:0]);
		for (int i = 0; i < bch_slot_count; i++)
			want[i] = model_syn(r[14:0], load_index(i));
		@(posedge clk);
		@(negedge clk);
		compare_slots(want);
		repeat (bch_slot_count) begin
			prev = want;
			for (int i = 0; i < bch_slot_count; i++) begin
				if (!(bch_t < 4 && i == bch_t + 1))
					want[i] = prev[(i + 2 * bch_t - 3) % bch_slot_count];
			end
			@(posedge clk);
			shuffle_ce <= 1'b1;
			@(posedge clk);
			shuffle_ce <= 1'b0;
			@(negedge clk);
			compare_slots(want);
		end
		report("shuffle order", e0);
	endtask

	// Second start after seven bits of the first word
	task restart_mid_word();
		int e0;
		int c0;
		int r1;
		int r2;
		int latency;
		e0 = errors;
		c0 = done_pulses;
		r1 = $random(seed);
		r2 = $random(seed);
		drive_word(r1[14:0], 7);
		drive_word(r2[14:0], bch_n);
		wait_done(latency);
		check_syndromes(r2[14:0]);
		repeat (2) @(posedge clk);
		@(negedge clk);
		checks++;
		if (done_pulses != c0 + 1) begin
			$display("Error at %0t: expected one done pulse, saw %0d", $time,
				done_pulses - c0);
			errors++;
		end
		report("restart mid word", e0);
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		data_in = 1'b0;
		shuffle_ce = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checks++;
		if (done !== 1'b0 || has_errors !== 1'b0 || syndromes !== '0 || syn_shuffled !== '0) begin
			$display("Error at %0t: outputs not cleared by reset", $time);
			errors++;
		end
		zero_word();
		single_bits();
		codeword_flips();
		random_words();
		shuffle_order();
		restart_mid_word();
		$display("Checks run: %0d, failed: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: all.f
design/gf_pkg.sv
design/bch_pkg.sv
design/lfsr_counter.sv
design/syndrome_accum.sv
design/bch_syndrome.sv
design/syndrome_shuffle.sv
design/bch_syndrome_unit.sv
verification/bch_syndrome_checker.sv
verification/bch_syndrome_tb.sv
